// File: rtl/ahbl_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared constants and types for the AHB-Lite SRAM slave
// Bus widths, memory map, response timing, bus codes, packed records
//////////////////////////////////////////////////////////////////////
`default_nettype none

package ahbl_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int BE_W   = DATA_W / 8; // One enable per byte lane

	// Memory map, 1 KiB of words from address zero
	localparam int MEM_WORDS  = 256;
	localparam int WORD_IDX_W = 8;
	localparam logic [ADDR_W-1:0] MEM_BYTES = ADDR_W'(MEM_WORDS * BE_W);

	// Response timing
	localparam int WAIT_STATES = 1; // Low hready_resp cycles per OKAY phase
	localparam int WAIT_CNT_W  = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
	localparam logic [WAIT_CNT_W-1:0] WAIT_LAST = WAIT_CNT_W'(WAIT_STATES);

	// Monitor stall limit, counter saturates above it
	localparam int MAX_STALL   = 4;
	localparam int STALL_CNT_W = $clog2(MAX_STALL + 2);

	// HTRANS codes
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_BUSY   = 2'b01;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	// HSIZE codes, anything above word is refused
	localparam logic [2:0] HSIZE_BYTE = 3'b000;
	localparam logic [2:0] HSIZE_HALF = 3'b001;
	localparam logic [2:0] HSIZE_WORD = 3'b010;

	// HRESP codes
	localparam logic HRESP_OKAY  = 1'b0;
	localparam logic HRESP_ERROR = 1'b1;

	// Address phase as seen on the bus
	typedef struct packed {
		logic [ADDR_W-1:0] haddr;
		logic              hwrite;
		logic [1:0]        htrans;
		logic [2:0]        hsize;
		logic              hsel;
	} ahbl_addr_t;

	// Data-phase record latched by the decoder
	typedef struct packed {
		logic                  active;   // Real transfer in data phase
		logic                  write;
		logic                  err;      // Answer with ERROR
		logic [WORD_IDX_W-1:0] word_idx;
		logic [BE_W-1:0]       byte_en;
	} ahbl_dph_t;

endpackage

`default_nettype wire

// File: rtl/ahbl_addr_decode.sv
//////////////////////////////////////////////////////////////////////
// Address-phase decoder: legality checks and byte-lane enables
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ahbl_addr_decode (
	input  logic                 clk,
	input  logic                 rst_n,
	input  ahbl_pkg::ahbl_addr_t addr_ph,
	input  logic                 hready,
	output ahbl_pkg::ahbl_dph_t  dph
);

	ahbl_pkg::ahbl_dph_t       dph_d;
	logic                      req;
	logic                      in_range;
	logic                      misalign;
	logic                      bad_size;
	logic [ahbl_pkg::BE_W-1:0] be;

	// NONSEQ or SEQ with select, BUSY falls out as idle
	assign req      = addr_ph.hsel && addr_ph.htrans[1];
	assign in_range = addr_ph.haddr < ahbl_pkg::MEM_BYTES;

	// Lane placement by size and low address bits
	always_comb begin
		misalign = 1'b0;
		bad_size = 1'b0;
		be       = '0;
		case (addr_ph.hsize)
			ahbl_pkg::HSIZE_BYTE: begin
				be = 4'b0001 << addr_ph.haddr[1:0];
			end
			ahbl_pkg::HSIZE_HALF: begin
				misalign = addr_ph.haddr[0];                      // Odd halfword
				be       = addr_ph.haddr[1] ? 4'b1100 : 4'b0011;
			end
			ahbl_pkg::HSIZE_WORD: begin
				misalign = |addr_ph.haddr[1:0];
				be       = 4'b1111;
			end
			default: bad_size = 1'b1; // Doubleword and up
		endcase
	end

	// Next record, only meaningful when req is set
	always_comb begin
		dph_d          = '0;
		dph_d.active   = req;
		dph_d.write    = addr_ph.hwrite;
		dph_d.err      = req && (!in_range || misalign || bad_size);
		dph_d.word_idx = addr_ph.haddr[ahbl_pkg::WORD_IDX_W+1:2];
		dph_d.byte_en  = req ? be : '0;
	end

	// Record advances only when the bus moves
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph <= '0;
		end else if (hready) begin
			dph <= dph_d;
		end
	end

	// A legal access always touches at least one lane
	a_be_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
		dph.active && !dph.err |-> dph.byte_en != '0)
		else $error("decode: empty byte enables on legal access");

endmodule

`default_nettype wire

// File: rtl/ahbl_sram_exec.sv
//////////////////////////////////////////////////////////////////////
// SRAM array with byte-lane writes and a registered read port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ahbl_sram_exec (
	input  logic                        clk,
	input  ahbl_pkg::ahbl_dph_t         dph,
	input  logic                        issue,
	input  logic                        hready_resp,
	input  logic [ahbl_pkg::DATA_W-1:0] hwdata,
	output logic [ahbl_pkg::DATA_W-1:0] hrdata
);

	logic [ahbl_pkg::DATA_W-1:0] mem [ahbl_pkg::MEM_WORDS];
	logic                        wr_commit;
	logic                        rd_fire;

	// hwdata is valid on the last cycle of the write data phase
	assign wr_commit = hready_resp && dph.active && dph.write && !dph.err;

	// Read launched at the start of the data phase
	assign rd_fire = issue && !dph.write;

	// Byte-lane write
	always_ff @(posedge clk) begin
		if (wr_commit) begin
			for (int i = 0; i < ahbl_pkg::BE_W; i++) begin
				if (dph.byte_en[i]) begin
					mem[dph.word_idx][8*i +: 8] <= hwdata[8*i +: 8];
				end
			end
		end
	end

	// Full word always returned, master picks its lanes
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			hrdata <= mem[dph.word_idx];
		end
	end

	// No read strobe for an erroring record
	a_err_no_read: assert property (@(posedge clk)
		dph.active && dph.err |-> !issue)
		else $error("exec: read issued for an erroring transfer");

	// Every commit closes an OKAY phase issued WAIT_STATES cycles earlier
	a_commit_issued: assert property (@(posedge clk)
		wr_commit |-> $past(issue, ahbl_pkg::WAIT_STATES))
		else $error("exec: write commit without an issued OKAY phase");

endmodule

`default_nettype wire

// File: rtl/ahbl_resp_gen.sv
//////////////////////////////////////////////////////////////////////
// Response FSM: wait states, two-cycle ERROR, issue strobe to memory
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ahbl_resp_gen (
	input  logic                clk,
	input  logic                rst_n,
	input  ahbl_pkg::ahbl_dph_t dph,
	input  logic                hready,
	output logic                hready_resp,
	output logic                hresp,
	output logic                issue
);

	typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_ERR1, ST_ERR2} rsp_st_t;

	rsp_st_t                         st_q;
	rsp_st_t                         st_cur;
	rsp_st_t                         st_nxt;
	logic [ahbl_pkg::WAIT_CNT_W-1:0] cnt_q;
	logic [ahbl_pkg::WAIT_CNT_W-1:0] cnt_cur;
	logic [ahbl_pkg::WAIT_CNT_W-1:0] cnt_nxt;
	logic                            cnt_done;

	// First cycle of a phase is taken straight from the record
	always_comb begin
		st_cur  = st_q;
		cnt_cur = cnt_q;
		if (st_q == ST_IDLE) begin
			cnt_cur = '0;
			if (dph.active) begin
				st_cur = dph.err ? ST_ERR1 : ST_WAIT;
			end
		end
	end

	assign cnt_done = cnt_cur == ahbl_pkg::WAIT_LAST;
	assign issue    = (st_q == ST_IDLE) && (st_cur == ST_WAIT); // One pulse per phase

	always_comb begin
		hready_resp = 1'b1;                 // Idle phase, OKAY at once
		hresp       = ahbl_pkg::HRESP_OKAY;
		st_nxt      = st_cur;
		cnt_nxt     = cnt_cur;
		case (st_cur)
			ST_WAIT: begin
				hready_resp = cnt_done;
				if (!cnt_done) begin
					cnt_nxt = cnt_cur + 1'b1;
				end else if (hready) begin
					st_nxt = ST_IDLE;
				end
			end
			ST_ERR1: begin
				hready_resp = 1'b0;             // Give the master a cycle to cancel
				hresp       = ahbl_pkg::HRESP_ERROR;
				st_nxt      = ST_ERR2;
			end
			ST_ERR2: begin
				hresp = ahbl_pkg::HRESP_ERROR;
				if (hready) st_nxt = ST_IDLE;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			st_q  <= ST_IDLE;
			cnt_q <= '0;
		end else begin
			st_q  <= st_nxt;
			cnt_q <= cnt_nxt;
		end
	end

endmodule

`default_nettype wire

// File: rtl/ahbl_resp_monitor.sv
//////////////////////////////////////////////////////////////////////
// Response monitor: own data-phase tracker and AHB-Lite response checks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ahbl_resp_monitor (
	input  logic                 clk,
	input  logic                 rst_n,
	input  ahbl_pkg::ahbl_addr_t addr_ph,
	input  logic                 hready,
	input  logic                 hready_resp,
	input  logic                 hresp
);

	logic                             req;
	logic                             act_q;     // Our transfer in data phase
	logic [ahbl_pkg::STALL_CNT_W-1:0] stall_cnt;

	// Tracked independently of the decoder
	assign req = addr_ph.hsel &&
		!(addr_ph.htrans inside {ahbl_pkg::HTRANS_IDLE, ahbl_pkg::HTRANS_BUSY});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			act_q     <= 1'b0;
			stall_cnt <= '0;
		end else begin
			if (hready) act_q <= req;
			if (hready) begin
				stall_cnt <= '0;
			end else if (!(&stall_cnt)) begin
				stall_cnt <= stall_cnt + 1'b1; // Saturate, never wrap back under limit
			end
		end
	end

	// Idle phase: OKAY, zero wait
	a_idle_okay: assert property (@(posedge clk) disable iff (!rst_n)
		!act_q |-> hready_resp && hresp == ahbl_pkg::HRESP_OKAY)
		else $error("monitor: idle data phase not answered OKAY");

	// Second ERROR cycle needs the first one just before
	a_err_second: assert property (@(posedge clk) disable iff (!rst_n)
		hresp && hready_resp |-> $past(hresp) && !$past(hready_resp))
		else $error("monitor: ERROR completed without the stall cycle");

	// First ERROR cycle must carry on into the second
	a_err_first: assert property (@(posedge clk) disable iff (!rst_n)
		hresp && !hready_resp |=> hresp)
		else $error("monitor: ERROR dropped after first cycle");

	a_stall_limit: assert property (@(posedge clk) disable iff (!rst_n)
		stall_cnt <= ahbl_pkg::MAX_STALL)
		else $error("monitor: hready held low too long");

endmodule

`default_nettype wire

// File: rtl/ahbl_sram_slave.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite SRAM slave top: decode, memory, response FSM and monitor
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ahbl_sram_slave (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        hsel,
	input  logic [ahbl_pkg::ADDR_W-1:0] haddr,
	input  logic                        hwrite,
	input  logic [1:0]                  htrans,
	input  logic [2:0]                  hsize,
	input  logic [2:0]                  hburst,  // Accepted, same answer every beat
	input  logic [ahbl_pkg::DATA_W-1:0] hwdata,
	input  logic                        hready,  // System ready from the fabric
	output logic                        hready_resp,
	output logic                        hresp,
	output logic [ahbl_pkg::DATA_W-1:0] hrdata
);

	ahbl_pkg::ahbl_addr_t addr_ph;
	ahbl_pkg::ahbl_dph_t  dph;
	logic                 issue;

	// Bundle the address phase
	always_comb begin
		addr_ph.haddr  = haddr;
		addr_ph.hwrite = hwrite;
		addr_ph.htrans = htrans;
		addr_ph.hsize  = hsize;
		addr_ph.hsel   = hsel;
	end

	ahbl_addr_decode u_decode (.clk(clk), .rst_n(rst_n), .addr_ph(addr_ph),
		.hready(hready), .dph(dph));

	ahbl_sram_exec u_exec (.clk(clk), .dph(dph), .issue(issue),
		.hready_resp(hready_resp), .hwdata(hwdata), .hrdata(hrdata));

	ahbl_resp_gen u_resp (.clk(clk), .rst_n(rst_n), .dph(dph), .hready(hready),
		.hready_resp(hready_resp), .hresp(hresp), .issue(issue));

	// Checker only, no outputs
	ahbl_resp_monitor u_mon (.clk(clk), .rst_n(rst_n), .addr_ph(addr_ph),
		.hready(hready), .hready_resp(hready_resp), .hresp(hresp));

endmodule

`default_nettype wire

// File: tb/tb_ahbl_sram_slave.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the AHB-Lite SRAM slave
// Transfer tasks, shadow memory, reset/word/lane/error/pipeline tests
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_ahbl_sram_slave;

	logic                        clk;
	logic                        rst_n;
	logic                        hsel;
	logic [ahbl_pkg::ADDR_W-1:0] haddr;
	logic                        hwrite;
	logic [1:0]                  htrans;
	logic [2:0]                  hsize;
	logic [2:0]                  hburst;
	logic [ahbl_pkg::DATA_W-1:0] hwdata;
	logic                        hready_resp;
	logic                        hresp;
	logic [ahbl_pkg::DATA_W-1:0] hrdata;
	logic [ahbl_pkg::DATA_W-1:0] shadow [ahbl_pkg::MEM_WORDS]; // Expected memory
	integer                      seed;

	// Single slave, system ready looped back
	ahbl_sram_slave u_dut (.clk(clk), .rst_n(rst_n), .hsel(hsel), .haddr(haddr),
		.hwrite(hwrite), .htrans(htrans), .hsize(hsize), .hburst(hburst),
		.hwdata(hwdata), .hready(hready_resp), .hready_resp(hready_resp),
		.hresp(hresp), .hrdata(hrdata));

	always #2 clk = ~clk; // 4 ns period

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
			else stop_with_error($sformatf("FAIL %s: got 0x%08h, expected 0x%08h",
				name, got, exp));
	endtask

	// Lanes picked by size and low address bits, rest kept
	function automatic logic [31:0] merge_lanes(input logic [31:0] old,
		input logic [31:0] addr, input logic [2:0] size, input logic [31:0] data);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (size == ahbl_pkg::HSIZE_WORD ||
				(size == ahbl_pkg::HSIZE_HALF && (b / 2) == int'(addr[1])) ||
				(size == ahbl_pkg::HSIZE_BYTE && b == int'(addr[1:0]))) begin
				res[8*b +: 8] = data[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic put_address(input logic [31:0] addr, input logic write,
		input logic [2:0] size);
		hsel   = 1'b1;
		haddr  = addr;
		hwrite = write;
		hsize  = size;
		htrans = ahbl_pkg::HTRANS_NONSEQ;
	endtask

	// Returns on the first data-phase falling edge
	task automatic wait_accept();
		int n;
		n = 0;
		while (!hready_resp) begin
			n++;
			assert (n <= ahbl_pkg::MAX_STALL)
				else stop_with_error("address phase never accepted, hready_resp stuck low");
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	// Counts stall cycles and hresp cycles up to the ready cycle
	task automatic collect_phase(output int lows, output int errs);
		lows = 0;
		errs = 0;
		while (!hready_resp) begin
			if (hresp) errs++;
			lows++;
			assert (lows <= ahbl_pkg::MAX_STALL)
				else stop_with_error("data phase never completed, hready_resp stuck low");
			@(negedge clk);
		end
		if (hresp) errs++;
	endtask

	task automatic do_transfer(input logic [31:0] addr, input logic write,
		input logic [2:0] size, input logic [31:0] wdata, output logic [31:0] rdata,
		output int lows, output int errs);
		@(negedge clk);
		put_address(addr, write, size);
		wait_accept();
		hsel   = 1'b0;
		htrans = ahbl_pkg::HTRANS_IDLE;
		hwdata = wdata;                 // Write data lives in the data phase
		collect_phase(lows, errs);
		rdata = hrdata;                 // Valid in the ready cycle
	endtask

	task automatic expect_okay(input int lows, input int errs);
		expect_value("hready_resp low cycles", lows, ahbl_pkg::WAIT_STATES);
		expect_value("hresp cycles", errs, 32'h0);
	endtask

	task automatic ahb_write(input logic [31:0] addr, input logic [2:0] size,
		input logic [31:0] data);
		logic [31:0] unused_rd;
		int          lows;
		int          errs;
		do_transfer(addr, 1'b1, size, data, unused_rd, lows, errs);
		expect_okay(lows, errs);
		shadow[addr[ahbl_pkg::WORD_IDX_W+1:2]] =
			merge_lanes(shadow[addr[ahbl_pkg::WORD_IDX_W+1:2]], addr, size, data);
	endtask

	// Word read compared against the shadow
	task automatic ahb_read(input logic [31:0] addr);
		logic [31:0] rd;
		int          lows;
		int          errs;
		do_transfer(addr, 1'b0, ahbl_pkg::HSIZE_WORD, 32'h0, rd, lows, errs);
		expect_okay(lows, errs);
		expect_value("hrdata", rd, shadow[addr[ahbl_pkg::WORD_IDX_W+1:2]]);
	endtask

	task automatic ahb_idle();
		@(negedge clk);
		hsel   = 1'b1;
		htrans = ahbl_pkg::HTRANS_IDLE;
		wait_accept();
		hsel = 1'b0;
		expect_value("hready_resp", 32'(hready_resp), 32'h1); // No wait on idle
		expect_value("hresp", 32'(hresp), 32'h0);
	endtask

	// Two cycles of ERROR, first stalled
	task automatic error_transfer(input logic [31:0] addr, input logic write,
		input logic [2:0] size);
		logic [31:0] unused_rd;
		int          lows;
		int          errs;
		do_transfer(addr, write, size, $random(seed), unused_rd, lows, errs);
		expect_value("hresp cycles", errs, 32'h2);
		expect_value("hready_resp low cycles", lows, 32'h1);
	endtask

	// Read address phase overlaps the write data phase
	task automatic write_then_read(input logic [31:0] addr, input logic [31:0] data);
		int lows;
		int errs;
		@(negedge clk);
		put_address(addr, 1'b1, ahbl_pkg::HSIZE_WORD);
		wait_accept();
		hwdata = data;
		put_address(addr, 1'b0, ahbl_pkg::HSIZE_WORD);
		collect_phase(lows, errs);
		expect_okay(lows, errs);
		shadow[addr[ahbl_pkg::WORD_IDX_W+1:2]] = data;
		@(negedge clk);
		hsel   = 1'b0;
		htrans = ahbl_pkg::HTRANS_IDLE;
		collect_phase(lows, errs);
		expect_okay(lows, errs);
		expect_value("hrdata", hrdata, data);
	endtask

	task automatic reset_state_check();
		expect_value("hready_resp", 32'(hready_resp), 32'h1);
		expect_value("hresp", 32'(hresp), 32'h0);
		ahb_idle();
	endtask

	task automatic word_readback();
		logic [31:0] addrs [5];
		addrs = '{32'h000, 32'h004, 32'h0f0, 32'h200, 32'h3fc}; // Both ends of the map
		foreach (addrs[i]) ahb_write(addrs[i], ahbl_pkg::HSIZE_WORD, $random(seed));
		foreach (addrs[i]) ahb_read(addrs[i]);
	endtask

	task automatic byte_lane_writes();
		for (int w = 0; w < 2; w++) begin
			ahb_write(32'h40 + 4 * w, ahbl_pkg::HSIZE_WORD, $random(seed)); // Known base
			for (int off = 0; off < 4; off++) begin
				ahb_write(32'h40 + 4 * w + off, ahbl_pkg::HSIZE_BYTE, $random(seed));
				ahb_read(32'h40 + 4 * w);
			end
			for (int off = 0; off < 4; off += 2) begin
				ahb_write(32'h40 + 4 * w + off, ahbl_pkg::HSIZE_HALF, $random(seed));
				ahb_read(32'h40 + 4 * w);
			end
		end
	endtask

	task automatic error_responses();
		ahb_write(32'h100, ahbl_pkg::HSIZE_WORD, $random(seed)); // Preset target
		error_transfer(32'h400, 1'b0, ahbl_pkg::HSIZE_WORD);     // Read past 1 KiB
		error_transfer(32'h500, 1'b1, ahbl_pkg::HSIZE_WORD);     // Would alias 0x100
		error_transfer(32'h102, 1'b1, ahbl_pkg::HSIZE_WORD);
		error_transfer(32'h101, 1'b1, ahbl_pkg::HSIZE_HALF);
		error_transfer(32'h100, 1'b1, 3'b011);                   // Doubleword
		ahb_read(32'h100);
	endtask

	task automatic pipelined_pair();
		write_then_read(32'h080, $random(seed));
		write_then_read(32'h3f8, $random(seed));
		ahb_read(32'h080);
	endtask

	initial begin
		seed   = 32'h1b50;
		clk    = 1'b0;
		rst_n  = 1'b0;
		hsel   = 1'b0;
		haddr  = '0;
		hwrite = 1'b0;
		htrans = ahbl_pkg::HTRANS_IDLE;
		hsize  = ahbl_pkg::HSIZE_WORD;
		hburst = 3'b000;
		hwdata = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		reset_state_check();
		word_readback();
		byte_lane_writes();
		error_responses();
		pipelined_pair();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: ahbl_sram_slave.f
rtl/ahbl_pkg.sv
rtl/ahbl_addr_decode.sv
rtl/ahbl_sram_exec.sv
rtl/ahbl_resp_gen.sv
rtl/ahbl_resp_monitor.sv
rtl/ahbl_sram_slave.sv
tb/tb_ahbl_sram_slave.sv

// File: Makefile
# Verilator build and run for the AHB-Lite SRAM slave testbench

VERILATOR ?= verilator
TOP       ?= tb_ahbl_sram_slave
FILELIST  ?= ahbl_sram_slave.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(wildcard rtl/*.sv tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "tests failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
